// File: hw/core_pkg.sv
package core_pkg;

    localparam int data_w     = 16;
    localparam int reg_count  = 16;
    localparam int reg_addr_w = 4;
    localparam int count_w    = 16;

    // the shift ops use the low 4 bits of operand b as the distance
    typedef enum logic [3:0] {
        op_nop = 4'h0,
        op_add = 4'h1,
        op_sub = 4'h2,
        op_and = 4'h3,
        op_or  = 4'h4,
        op_xor = 4'h5,
        op_shl = 4'h6,
        op_shr = 4'h7,
        op_ldi = 4'h8
    } opcode_e;

    // for op_ldi the rs and rt fields together form the 8-bit immediate
    typedef struct packed {
        opcode_e                 opcode;
        logic [reg_addr_w-1:0]   rd;
        logic [reg_addr_w-1:0]   rs;
        logic [reg_addr_w-1:0]   rt;
    } instr_t;

    typedef struct packed {
        logic zero;
        logic negative;
        logic carry;
    } flags_t;

    typedef struct packed {
        opcode_e                 opcode;
        logic [reg_addr_w-1:0]   rd;
        logic                    writes;
        logic [data_w-1:0]       a;
        logic [data_w-1:0]       b;
    } exec_t;

    typedef struct packed {
        logic [reg_addr_w-1:0]   rd;
        logic [data_w-1:0]       value;
        flags_t                  flags;
    } result_t;

endpackage

// File: hw/pipe_reg.sv
`timescale 1ns/10ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     hold,
    input  logic     load,
    input  payload_t d,
    output payload_t q,
    output logic     valid,
    output logic     fresh
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid <= 1'b0;
        end else if (!hold) begin
            valid <= load;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            q <= d;
        end
    end

    // a load made just before a hold is reported once the hold lifts
    assign fresh = valid & ~hold;

endmodule

// File: hw/reg_file.sv
`timescale 1ns/10ps

module reg_file (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [core_pkg::reg_addr_w-1:0]  raddr_a,
    input  logic [core_pkg::reg_addr_w-1:0]  raddr_b,
    output logic [core_pkg::data_w-1:0]      rdata_a,
    output logic [core_pkg::data_w-1:0]      rdata_b,
    input  logic                             wen,
    input  logic [core_pkg::reg_addr_w-1:0]  waddr,
    input  logic [core_pkg::data_w-1:0]      wdata
);

    logic [core_pkg::data_w-1:0] regs [core_pkg::reg_count];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < core_pkg::reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wen) begin
            regs[waddr] <= wdata;
        end
    end

    // reads see the old value during a write and the decode bypass covers that case
    assign rdata_a = regs[raddr_a];
    assign rdata_b = regs[raddr_b];

endmodule

// File: hw/alu.sv
`timescale 1ns/10ps

module alu (
    input  core_pkg::opcode_e            opcode,
    input  logic [core_pkg::data_w-1:0]  a,
    input  logic [core_pkg::data_w-1:0]  b,
    output logic [core_pkg::data_w-1:0]  value,
    output core_pkg::flags_t             flags
);

    logic [core_pkg::data_w:0] sum;
    logic [core_pkg::data_w:0] diff;
    logic                      carry;

    assign sum  = {1'b0, a} + {1'b0, b};
    // carry out of a + ~b + 1 is set when there is no borrow
    assign diff = {1'b0, a} + {1'b0, ~b} + 1'b1;

    always_comb begin
        value = '0;
        carry = 1'b0;
        case (opcode)
            core_pkg::op_add: begin
                value = sum[core_pkg::data_w-1:0];
                carry = sum[core_pkg::data_w];
            end
            core_pkg::op_sub: begin
                value = diff[core_pkg::data_w-1:0];
                carry = diff[core_pkg::data_w];
            end
            core_pkg::op_and: value = a & b;
            core_pkg::op_or:  value = a | b;
            core_pkg::op_xor: value = a ^ b;
            core_pkg::op_shl: value = a << b[3:0];
            core_pkg::op_shr: value = a >> b[3:0];
            core_pkg::op_ldi: value = b;
            default: begin
                value = '0;
                carry = 1'b0;
            end
        endcase
    end

    assign flags.zero     = (value == '0);
    assign flags.negative = value[core_pkg::data_w-1];
    assign flags.carry    = carry;

endmodule

// File: hw/decode_stage.sv
`timescale 1ns/10ps

module decode_stage (
    input  core_pkg::instr_t                 instr,
    output logic [core_pkg::reg_addr_w-1:0]  raddr_a,
    output logic [core_pkg::reg_addr_w-1:0]  raddr_b,
    input  logic [core_pkg::data_w-1:0]      rdata_a,
    input  logic [core_pkg::data_w-1:0]      rdata_b,
    input  logic                             fwd_valid,
    input  logic [core_pkg::reg_addr_w-1:0]  fwd_rd,
    input  logic [core_pkg::data_w-1:0]      fwd_value,
    output core_pkg::exec_t                  payload
);

    logic                        hit_a;
    logic                        hit_b;
    logic [core_pkg::data_w-1:0] imm;

    assign raddr_a = instr.rs;
    assign raddr_b = instr.rt;

    // fwd_valid is only set for an in-flight instruction that writes
    assign hit_a = fwd_valid && (fwd_rd == instr.rs);
    assign hit_b = fwd_valid && (fwd_rd == instr.rt);

    assign imm = {{(core_pkg::data_w - 8){1'b0}}, instr.rs, instr.rt};

    always_comb begin
        payload.opcode = instr.opcode;
        payload.rd     = instr.rd;
        payload.writes = (instr.opcode != core_pkg::op_nop);
        payload.a      = hit_a ? fwd_value : rdata_a;

        if (instr.opcode == core_pkg::op_ldi) begin
            payload.b = imm;
        end else if (hit_b) begin
            payload.b = fwd_value;
        end else begin
            payload.b = rdata_b;
        end
    end

endmodule

// File: hw/execute_stage.sv
`timescale 1ns/10ps

module execute_stage (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             hold,
    input  core_pkg::exec_t                  payload,
    input  logic                             payload_valid,
    output logic                             fwd_valid,
    output logic [core_pkg::reg_addr_w-1:0]  fwd_rd,
    output logic [core_pkg::data_w-1:0]      fwd_value,
    output logic                             wen,
    output logic [core_pkg::reg_addr_w-1:0]  waddr,
    output logic [core_pkg::data_w-1:0]      wdata,
    output core_pkg::result_t                result,
    output logic                             result_valid
);

    logic [core_pkg::data_w-1:0] alu_value;
    core_pkg::flags_t            alu_flags;
    core_pkg::result_t           result_d;

    alu u_alu (
        .opcode (payload.opcode),
        .a      (payload.a),
        .b      (payload.b),
        .value  (alu_value),
        .flags  (alu_flags)
    );

    assign fwd_valid = payload_valid && payload.writes;
    assign fwd_rd    = payload.rd;
    assign fwd_value = alu_value;

    // the register file and the result register update on the same edge
    assign wen   = fwd_valid && !hold;
    assign waddr = payload.rd;
    assign wdata = alu_value;

    assign result_d.rd    = payload.rd;
    assign result_d.value = alu_value;
    assign result_d.flags = alu_flags;

    pipe_reg #(.payload_t(core_pkg::result_t)) u_result_reg (
        .clk   (clk),
        .rst   (rst),
        .hold  (hold),
        .load  (wen),
        .d     (result_d),
        .q     (result),
        .valid (),
        .fresh (result_valid)
    );

endmodule

// File: hw/pipe_ctrl.sv
`timescale 1ns/10ps

module pipe_ctrl (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          instr_valid,
    input  logic                          halt_req,
    input  logic                          resume_req,
    input  logic                          result_valid,
    output logic                          accept,
    output logic                          hold,
    output logic                          halted,
    output logic                          instr_drop,
    output logic [core_pkg::count_w-1:0]  retired_count
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            halted        <= 1'b0;
            instr_drop    <= 1'b0;
            retired_count <= '0;
        end else begin
            // halt_req has priority when both strobes arrive together
            if (halt_req) begin
                halted <= 1'b1;
            end else if (resume_req) begin
                halted <= 1'b0;
            end

            instr_drop <= instr_valid && halted;

            if (result_valid) begin
                retired_count <= retired_count + 1'b1;
            end
        end
    end

    assign accept = instr_valid && !halted;
    assign hold   = halted;

endmodule

// File: hw/alu_core.sv
`timescale 1ns/10ps

module alu_core (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          instr_valid,
    input  core_pkg::instr_t              instr,
    input  logic                          halt_req,
    input  logic                          resume_req,
    output logic                          result_valid,
    output core_pkg::result_t             result,
    output logic                          instr_drop,
    output logic                          halted,
    output logic [core_pkg::count_w-1:0]  retired_count
);

    logic                            accept;
    logic                            hold;
    logic [core_pkg::reg_addr_w-1:0] raddr_a;
    logic [core_pkg::reg_addr_w-1:0] raddr_b;
    logic [core_pkg::data_w-1:0]     rdata_a;
    logic [core_pkg::data_w-1:0]     rdata_b;
    logic                            fwd_valid;
    logic [core_pkg::reg_addr_w-1:0] fwd_rd;
    logic [core_pkg::data_w-1:0]     fwd_value;
    logic                            wen;
    logic [core_pkg::reg_addr_w-1:0] waddr;
    logic [core_pkg::data_w-1:0]     wdata;
    core_pkg::exec_t                 dec_payload;
    core_pkg::exec_t                 exec_payload;
    logic                            exec_valid;

    pipe_ctrl u_pipe_ctrl (
        .clk           (clk),
        .rst           (rst),
        .instr_valid   (instr_valid),
        .halt_req      (halt_req),
        .resume_req    (resume_req),
        .result_valid  (result_valid),
        .accept        (accept),
        .hold          (hold),
        .halted        (halted),
        .instr_drop    (instr_drop),
        .retired_count (retired_count)
    );

    decode_stage u_decode_stage (
        .instr     (instr),
        .raddr_a   (raddr_a),
        .raddr_b   (raddr_b),
        .rdata_a   (rdata_a),
        .rdata_b   (rdata_b),
        .fwd_valid (fwd_valid),
        .fwd_rd    (fwd_rd),
        .fwd_value (fwd_value),
        .payload   (dec_payload)
    );

    // the decode to execute register is filled only by accepted strobes
    pipe_reg #(.payload_t(core_pkg::exec_t)) u_exec_reg (
        .clk   (clk),
        .rst   (rst),
        .hold  (hold),
        .load  (accept),
        .d     (dec_payload),
        .q     (exec_payload),
        .valid (exec_valid),
        .fresh ()
    );

    execute_stage u_execute_stage (
        .clk           (clk),
        .rst           (rst),
        .hold          (hold),
        .payload       (exec_payload),
        .payload_valid (exec_valid),
        .fwd_valid     (fwd_valid),
        .fwd_rd        (fwd_rd),
        .fwd_value     (fwd_value),
        .wen           (wen),
        .waddr         (waddr),
        .wdata         (wdata),
        .result        (result),
        .result_valid  (result_valid)
    );

    reg_file u_reg_file (
        .clk     (clk),
        .rst     (rst),
        .raddr_a (raddr_a),
        .raddr_b (raddr_b),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b),
        .wen     (wen),
        .waddr   (waddr),
        .wdata   (wdata)
    );

endmodule

// File: dv/alu_core_checker.sv
`timescale 1ns/10ps

module alu_core_checker (
    input logic clk,
    input logic rst,
    input logic instr_valid,
    input logic halt_req,
    input logic result_valid,
    input logic instr_drop,
    input logic halted
);

    // both strobes stay quiet for the whole reset
    reset_quiet: assert property (@(posedge clk) rst |-> !result_valid && !instr_drop)
        else $error("result_valid or instr_drop high during reset");

    no_result_halted: assert property (@(posedge clk) disable iff (rst)
        result_valid |-> !halted)
        else $error("result_valid high while halted");

    // a drop pulse answers a strobe seen in the previous cycle while halted
    drop_after_strobe: assert property (@(posedge clk) disable iff (rst)
        instr_drop |-> $past(instr_valid && halted))
        else $error("instr_drop without a strobe during halt");

    halt_after_req: assert property (@(posedge clk) disable iff (rst)
        $rose(halted) |-> $past(halt_req))
        else $error("halted rose without halt_req");

endmodule

bind alu_core alu_core_checker u_alu_core_checker (
    .clk          (clk),
    .rst          (rst),
    .instr_valid  (instr_valid),
    .halt_req     (halt_req),
    .result_valid (result_valid),
    .instr_drop   (instr_drop),
    .halted       (halted)
);

// File: dv/alu_core_tb.sv
`timescale 1ns/10ps

module alu_core_tb;

    localparam int          fields     = 5;
    localparam int          max_lines  = 64;
    localparam int          wait_limit = 40;
    localparam logic [15:0] end_marker = 16'hffff;

    logic                          clk;
    logic                          rst;
    logic                          instr_valid;
    core_pkg::instr_t              instr;
    logic                          halt_req;
    logic                          resume_req;
    logic                          result_valid;
    core_pkg::result_t             result;
    logic                          instr_drop;
    logic                          halted;
    logic [core_pkg::count_w-1:0]  retired_count;

    // each line of the data file fills five consecutive words
    logic [15:0] test_mem [fields*max_lines];

    // expected results in issue order along with the cycle each one is due
    core_pkg::result_t exp_q   [$];
    int unsigned       due_q   [$];
    int unsigned       epoch_q [$];

    int unsigned cycle          = 0;
    int unsigned halt_epoch     = 0;
    int unsigned results_seen   = 0;
    int unsigned writes_issued  = 0;
    int unsigned drops_expected = 0;
    int unsigned drops_seen     = 0;

    alu_core u_alu_core (
        .clk           (clk),
        .rst           (rst),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .halt_req      (halt_req),
        .resume_req    (resume_req),
        .result_valid  (result_valid),
        .result        (result),
        .instr_drop    (instr_drop),
        .halted        (halted),
        .retired_count (retired_count)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic abort_run();
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [15:0] actual,
                               input logic [15:0] expected);
        assert (actual == expected) else begin
            $display("** Error: %s = %h, expected %h", name, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_result();
        core_pkg::result_t exp;
        int unsigned       due;
        int unsigned       epoch;
        assert (exp_q.size() != 0) else begin
            $display("result_valid was raised with no result outstanding");
            abort_run();
        end
        exp   = exp_q.pop_front();
        due   = due_q.pop_front();
        epoch = epoch_q.pop_front();
        check_value("result.rd", {12'h0, result.rd}, {12'h0, exp.rd});
        check_value("result.value", result.value, exp.value);
        check_value("result.flags", {13'h0, result.flags}, {13'h0, exp.flags});
        // with no halt since the strobe the result follows it by two edges
        if (epoch == halt_epoch) begin
            assert (cycle == due) else begin
                $display("result for r%0h arrived at cycle %0d instead of cycle %0d",
                         exp.rd, cycle, due);
                abort_run();
            end
        end
        results_seen++;
    endtask

    // outputs are registered, so they are steady at the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            if (result_valid) begin
                check_result();
            end
            if (instr_drop) begin
                drops_seen++;
            end
        end
    end

    task automatic apply_reset();
        rst         = 1'b1;
        instr_valid = 1'b0;
        halt_req    = 1'b0;
        resume_req  = 1'b0;
        exp_q.delete();
        due_q.delete();
        epoch_q.delete();
        results_seen   = 0;
        writes_issued  = 0;
        drops_expected = 0;
        drops_seen     = 0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic issue_instr(input logic [15:0] word, input logic writes,
                               input core_pkg::result_t exp);
        instr_valid = 1'b1;
        instr       = word;
        if (writes) begin
            exp_q.push_back(exp);
            due_q.push_back(cycle + 2);
            epoch_q.push_back(halt_epoch);
            writes_issued++;
        end
        @(negedge clk);
        instr_valid = 1'b0;
    endtask

    task automatic halt_window();
        int unsigned waited;
        int unsigned len;
        halt_req = 1'b1;
        @(negedge clk);
        halt_req = 1'b0;
        // results hidden by the halt show up from this falling edge on
        halt_epoch++;
        waited   = 0;
        while (!halted && waited < wait_limit) begin
            @(negedge clk);
            waited++;
        end
        assert (halted) else begin
            $display("halted did not rise after halt_req");
            abort_run();
        end
        len = 1 + $urandom % 6;
        repeat (len) begin
            check_value("result_valid", {15'h0, result_valid}, 16'h0);
            // about half of the halted cycles carry a strobe that gets dropped
            if ($urandom % 2 == 1) begin
                instr_valid = 1'b1;
                instr       = 16'($urandom);
                drops_expected++;
                @(negedge clk);
                instr_valid = 1'b0;
                check_value("instr_drop", {15'h0, instr_drop}, 16'h1);
            end else begin
                @(negedge clk);
            end
        end
        resume_req = 1'b1;
        @(negedge clk);
        resume_req = 1'b0;
        waited     = 0;
        while (halted && waited < wait_limit) begin
            @(negedge clk);
            waited++;
        end
        assert (!halted) else begin
            $display("halted did not fall after resume_req");
            abort_run();
        end
    endtask

    task automatic run_pass(input logic with_stalls);
        int unsigned       line;
        int unsigned       base;
        int unsigned       waited;
        core_pkg::result_t exp;
        apply_reset();
        check_value("result_valid", {15'h0, result_valid}, 16'h0);
        check_value("instr_drop", {15'h0, instr_drop}, 16'h0);
        check_value("halted", {15'h0, halted}, 16'h0);
        check_value("retired_count", retired_count, 16'h0);
        line = 0;
        base = 0;
        while (line < max_lines && test_mem[base] != end_marker) begin
            if (with_stalls) begin
                repeat ($urandom % 4) @(negedge clk);
                if (line == 4 || ($urandom % 100) < 20) begin
                    halt_window();
                end
            end
            exp.rd    = test_mem[base + 2][3:0];
            exp.value = test_mem[base + 3];
            exp.flags = test_mem[base + 4][2:0];
            issue_instr(test_mem[base], test_mem[base + 1][0], exp);
            line++;
            base = line * fields;
        end
        waited = 0;
        while (exp_q.size() != 0 && waited < wait_limit) begin
            @(negedge clk);
            waited++;
        end
        assert (exp_q.size() == 0) else begin
            $display("%0d results never arrived", exp_q.size());
            abort_run();
        end
        // a few quiet cycles catch a duplicated result and settle the counters
        repeat (4) @(negedge clk);
        check_value("retired_count", retired_count, results_seen[15:0]);
        check_value("result_valid count", results_seen[15:0], writes_issued[15:0]);
        check_value("instr_drop count", drops_seen[15:0], drops_expected[15:0]);
    endtask

    initial begin
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        halt_req    = 1'b0;
        resume_req  = 1'b0;
        void'($urandom(32'hb6132397));
        $readmemh("dv/alu_core_testdata.txt", test_mem);
        // back to back first, so every dependent pair goes through the bypass
        run_pass(1'b0);
        // then again from reset with random gaps and halt windows
        run_pass(1'b1);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// File: dv/alu_core_testdata.txt
// columns: instruction word, result expected, rd, value, flags
// flags hold zero, negative and carry from bit 2 down to bit 0, a word of ffff ends the list
1123 1 1 0000 4
827f 1 2 007f 0
8381 1 3 0081 0
1423 1 4 0100 0
2542 1 5 0081 1
2625 1 6 fffe 2
1766 1 7 fffc 3
3872 1 8 007c 0
4983 1 9 00fd 0
5a99 1 a 0000 4
8b04 1 b 0004 0
6c2b 1 c 07f0 0
7dcb 1 d 007f 0
8e13 1 e 0013 0
6f6e 1 f fff0 2
0f12 0 0 0000 0
71f3 1 1 7ff8 0
2211 1 2 0000 5
1322 1 3 0000 4
84ff 1 4 00ff 0
1574 1 5 00fb 1
0000 0 0 0000 0
565d 1 6 0084 0
2867 1 8 0088 0
ffff 0 0 0000 0

// File: tb.f
hw/core_pkg.sv
hw/pipe_reg.sv
hw/reg_file.sv
hw/alu.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/pipe_ctrl.sv
hw/alu_core.sv
dv/alu_core_checker.sv
dv/alu_core_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= alu_core_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps

SOURCES := $(wildcard hw/*.sv) $(wildcard dv/*.sv)
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
